// File: files.f
common/capture_pkg.sv
common/capture_ctrl_if.sv
rtl/pixel_sampler.sv
rtl/fletcher_checksum.sv
rtl/pixel_stats.sv
capture/capture_fsm.sv
capture/word_assembler.sv
rtl/img_capture_top.sv
tb/img_capture_asserts.sv
tb/img_capture_tb.sv

// File: tb/img_capture_tb.sv
module img_capture_tb;
    import capture_pkg::*;

    localparam int header_words = 8;
    localparam int lines        = 8;
    localparam int line_pixels  = 8;
    localparam int data_words   = header_words + lines * line_pixels;
    localparam int frame_words  = data_words + 2;
    localparam int count_w      = $clog2(4096 * 4096) + 1;

    logic                           clk;
    logic                           readout_rst;
    logic                           cmd_capture;
    logic [0:0]                     cmd_skip_count;
    logic [header_words*word_w-1:0] cmd_header;
    logic [pixel_w-1:0]             img_d;
    logic                           img_fv;
    logic                           img_lv;
    logic                           word_valid;
    logic [word_w-1:0]              word_data;
    logic                           capture_done;
    logic [count_w-1:0]             status_word_count;
    logic [stat_w-1:0]              status_highlight_count;
    logic [stat_w-1:0]              status_shadow_count;

    logic [31:0]       lfsr = 32'h105e_7692;
    logic [word_w-1:0] got_words[$];
    int                got_cycles[$];
    logic [word_w-1:0] exp_words[$];
    int                cycle = 0;
    int                toggles = 0;
    int                toggle_cycle = 0;
    logic              done_seen = 1'b0;
    int                errors = 0;
    int                test_errors = 0;
    int                tests = 0;
    int                exp_highlight = 0;
    int                exp_shadow = 0;

    img_capture_top #(.header_words(header_words)) UUT (
        .clk                    (clk),
        .readout_rst            (readout_rst),
        .cmd_capture            (cmd_capture),
        .cmd_skip_count         (cmd_skip_count),
        .cmd_header             (cmd_header),
        .img_d                  (img_d),
        .img_fv                 (img_fv),
        .img_lv                 (img_lv),
        .word_valid             (word_valid),
        .word_data              (word_data),
        .capture_done           (capture_done),
        .status_word_count      (status_word_count),
        .status_highlight_count (status_highlight_count),
        .status_shadow_count    (status_shadow_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Output monitor on the falling edge
    always @(negedge clk) begin
        cycle++;
        if (word_valid) begin
            got_words.push_back(word_data);
            got_cycles.push_back(cycle);
        end
        if (capture_done != done_seen) begin
            done_seen    = capture_done;
            toggles++;
            toggle_cycle = cycle;
        end
    end

    // ==============================
    // Helpers
    // ==============================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic logic [word_w-1:0] pixel_word(input logic [pixel_w-1:0] p);
        out_word_u u;
        u.pix.pixel_lo = p[7:0];
        u.pix.pad      = 4'd0;
        u.pix.pixel_hi = p[11:8];
        return u.raw;
    endfunction

    function automatic logic [15:0] swap_bytes(input logic [15:0] w);
        return {w[7:0], w[15:8]};
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (expected == actual) else begin
            $display("ERR %s %s expected %0h actual %0h", test, what, expected, actual);
            test_errors++;
        end
    endtask

    task abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic wait_words(input int n, input int limit);
        int k;
        k = 0;
        while (got_words.size() < n && k < limit) begin
            @(negedge clk);
            k++;
        end
        if (got_words.size() < n) abort_run("timed out waiting for output words");
    endtask

    // One 8x8 frame with block origins rotating through highlight, shadow and random
    task automatic drive_frame();
        int                 ln;
        int                 px;
        int                 k;
        logic [pixel_w-1:0] p;
        exp_highlight = 0;
        exp_shadow    = 0;
        k             = 0;
        img_fv        = 1'b1;
        repeat (2) @(negedge clk);
        for (ln = 0; ln < lines; ln++) begin
            for (px = 0; px < line_pixels; px++) begin
                p = pixel_w'(take_bits(pixel_w));
                if (ln % 4 == 0 && px % 4 == 0) begin
                    if (k % 3 == 0) p = p | 12'hfe0;
                    else if (k % 3 == 1) p = p & 12'h01f;
                    k++;
                    if (p[pixel_w-1 -: stat_bits] == '1) exp_highlight++;
                    else if (p[pixel_w-1 -: stat_bits] == '0) exp_shadow++;
                end
                img_lv = 1'b1;
                img_d  = p;
                exp_words.push_back(pixel_word(p));
                @(negedge clk);
            end
            img_lv = 1'b0;
            repeat (3) @(negedge clk);
        end
        img_fv = 1'b0;
        repeat (4) @(negedge clk);
    endtask

    // ==============================
    // Capture test
    // ==============================
    task automatic run_capture(input string name, input int skips);
        int base;
        int f;
        int i;
        int k;
        int a;
        int b;
        test_errors = 0;
        got_words.delete();
        got_cycles.delete();
        exp_words.delete();
        toggles = 0;
        for (i = 0; i < header_words; i++) begin
            cmd_header[(header_words-i)*word_w-1 -: word_w] = word_w'(take_bits(word_w));
        end
        cmd_skip_count = 1'(skips);
        cmd_capture    = ~cmd_capture;
        for (f = 0; f <= skips; f++) begin
            base = f * frame_words;
            for (i = 0; i < header_words; i++) begin
                exp_words.push_back(cmd_header[(header_words-i)*word_w-1 -: word_w]);
            end
            wait_words(base + header_words, 200);
            repeat (2) @(negedge clk);
            drive_frame();
            a = 0;
            b = 0;
            for (i = base; i < base + data_words; i++) begin
                a = (a + swap_bytes(exp_words[i])) % 65535;
                b = (b + a) % 65535;
            end
            exp_words.push_back(swap_bytes(a[15:0]));
            exp_words.push_back(swap_bytes(b[15:0]));
        end
        k = 0;
        while (toggles == 0 && k < 200) begin
            @(negedge clk);
            k++;
        end
        if (toggles == 0) abort_run("capture_done never toggled");
        repeat (10) @(negedge clk);

        check_value(name, "word total", exp_words.size(), got_words.size());
        if (got_words.size() == exp_words.size()) begin
            for (i = 0; i < exp_words.size(); i++) begin
                check_value(name, $sformatf("word %0d", i), exp_words[i], got_words[i]);
            end
            for (f = 0; f <= skips; f++) begin
                base = f * frame_words;
                for (i = 1; i < header_words; i++) begin
                    check_value(name, "header cycle", got_cycles[base+i-1] + 1,
                                got_cycles[base+i]);
                end
            end
            check_value(name, "done cycle", got_cycles[$] + 1, toggle_cycle);
        end
        check_value(name, "done toggles", 1, toggles);
        check_value(name, "word count", frame_words, status_word_count);
        check_value(name, "highlight count", exp_highlight, status_highlight_count);
        check_value(name, "shadow count", exp_shadow, status_shadow_count);
        $display("test %s: %0d errors", name, test_errors);
        errors += test_errors;
        tests++;
    endtask

    initial begin
        readout_rst    = 1'b0;
        cmd_capture    = 1'b0;
        cmd_skip_count = '0;
        cmd_header     = '0;
        img_d          = '0;
        img_fv         = 1'b0;
        img_lv         = 1'b0;
        repeat (10) @(negedge clk);
        readout_rst = 1'b1;

        // Quiet stream before the first command
        test_errors = 0;
        repeat (20) @(negedge clk);
        check_value("idle", "words", 0, got_words.size());
        check_value("idle", "done", 0, capture_done);
        $display("test idle: %0d errors", test_errors);
        errors += test_errors;
        tests++;

        run_capture("single_frame", 0);
        run_capture("skip_frame", 1);

        errors += UUT.u_asserts.fail_count;
        $display("tests %0d, errors %0d, assertion failures %0d",
                 tests, errors, UUT.u_asserts.fail_count);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tb/img_capture_asserts.sv
module img_capture_asserts (
    input logic                            clk,
    input logic                            readout_rst,
    input logic                            cmd_capture,
    input logic [capture_pkg::pixel_w-1:0] img_d,
    input logic                            img_lv,
    input capture_pkg::capture_state_e     fsm_state,
    input logic                            word_valid,
    input logic [capture_pkg::word_w-1:0]  word_data,
    input logic                            capture_done
);
    import capture_pkg::*;

    int   fail_count = 0;
    logic cmd_q;
    logic started;

    // Pixel back out of the little-endian word
    function automatic logic [pixel_w-1:0] pixel_of(input logic [word_w-1:0] w);
        out_word_u u;
        u.raw = w;
        return {u.pix.pixel_hi, u.pix.pixel_lo};
    endfunction

    // Armed by the first command toggle after reset
    always_ff @(posedge clk) begin
        cmd_q <= cmd_capture;
        if (!readout_rst) begin
            started <= 1'b0;
        end else if (cmd_capture != cmd_q) begin
            started <= 1'b1;
        end
    end

    // ==============================
    // Stream properties
    // ==============================
    idle_quiet: assert property (@(posedge clk) disable iff (!readout_rst)
        !started |-> !word_valid && $stable(capture_done))
        else begin
            fail_count++;
            $error("word stream or done toggle active before any capture command");
        end

    pixel_latency: assert property (@(posedge clk) disable iff (!readout_rst)
        img_lv ##1 (fsm_state == st_frame) |=>
            word_valid && (pixel_of(word_data) == $past(img_d, 2)))
        else begin
            fail_count++;
            $error("pixel did not appear as a word two cycles later");
        end

    // Done only toggles right behind the last checksum word
    done_after_word: assert property (@(posedge clk) disable iff (!readout_rst)
        $changed(capture_done) |-> $past(word_valid))
        else begin
            fail_count++;
            $error("capture_done toggled without a preceding word");
        end

endmodule

bind img_capture_top img_capture_asserts u_asserts (
    .clk          (clk),
    .readout_rst  (readout_rst),
    .cmd_capture  (cmd_capture),
    .img_d        (img_d),
    .img_lv       (img_lv),
    .fsm_state    (u_fsm.state),
    .word_valid   (word_valid),
    .word_data    (word_data),
    .capture_done (capture_done)
);

// File: rtl/img_capture_top.sv
module img_capture_top #(
    parameter int header_words    = 8,
    parameter int max_image_words = 4096 * 4096,
    parameter int skip_w          = 1
) (
    input  logic                                        clk,
    input  logic                                        readout_rst,
    input  logic                                        cmd_capture,
    input  logic [skip_w-1:0]                           cmd_skip_count,
    input  logic [header_words*capture_pkg::word_w-1:0] cmd_header,
    input  logic [capture_pkg::pixel_w-1:0]             img_d,
    input  logic                                        img_fv,
    input  logic                                        img_lv,
    output logic                                        word_valid,
    output logic [capture_pkg::word_w-1:0]              word_data,
    output logic                                        capture_done,
    output logic [$clog2(max_image_words):0]            status_word_count,
    output logic [capture_pkg::stat_w-1:0]              status_highlight_count,
    output logic [capture_pkg::stat_w-1:0]              status_shadow_count
);
    logic [capture_pkg::pixel_w-1:0] pixel;
    logic                            fv;
    logic                            lv;
    logic                            block_origin;
    logic                            stat_clear;
    logic                            stat_sample;

    capture_ctrl_if ctrl_bus ();

    // ==============================
    // Pixel input
    // ==============================
    pixel_sampler u_sampler (
        .clk          (clk),
        .readout_rst  (readout_rst),
        .img_d        (img_d),
        .img_fv       (img_fv),
        .img_lv       (img_lv),
        .pixel        (pixel),
        .fv           (fv),
        .lv           (lv),
        .block_origin (block_origin)
    );

    capture_fsm #(
        .header_words (header_words),
        .skip_w       (skip_w)
    ) u_fsm (
        .clk            (clk),
        .readout_rst    (readout_rst),
        .cmd_capture    (cmd_capture),
        .cmd_skip_count (cmd_skip_count),
        .fv             (fv),
        .lv             (lv),
        .block_origin   (block_origin),
        .stat_clear     (stat_clear),
        .stat_sample    (stat_sample),
        .capture_done   (capture_done),
        .ctrl           (ctrl_bus.fsm)
    );

    // ==============================
    // Output stream and status
    // ==============================
    word_assembler #(
        .header_words    (header_words),
        .max_image_words (max_image_words)
    ) u_assembler (
        .clk         (clk),
        .readout_rst (readout_rst),
        .cmd_header  (cmd_header),
        .pixel       (pixel),
        .ctrl        (ctrl_bus.assembler),
        .word_valid  (word_valid),
        .word_data   (word_data),
        .word_count  (status_word_count)
    );

    pixel_stats u_stats (
        .clk             (clk),
        .readout_rst     (readout_rst),
        .clear           (stat_clear),
        .sample          (stat_sample),
        .pixel           (pixel),
        .highlight_count (status_highlight_count),
        .shadow_count    (status_shadow_count)
    );

endmodule

// File: capture/word_assembler.sv
module word_assembler #(
    parameter int header_words    = 8,
    parameter int max_image_words = 4096 * 4096
) (
    input  logic                                         clk,
    input  logic                                         readout_rst,
    input  logic [header_words*capture_pkg::word_w-1:0]  cmd_header,
    input  logic [capture_pkg::pixel_w-1:0]              pixel,
    capture_ctrl_if.assembler                            ctrl,
    output logic                                         word_valid,
    output logic [capture_pkg::word_w-1:0]               word_data,
    output logic [$clog2(max_image_words):0]             word_count
);
    import capture_pkg::*;

    localparam int header_bits = header_words * word_w;
    localparam int count_w     = $clog2(max_image_words) + 1;

    logic [header_bits-1:0] header_sr;
    logic [checksum_w-1:0]  checksum;
    logic [checksum_w-1:0]  checksum_hold;
    logic                   sum_en;
    out_word_u              next_word;

    // ==============================
    // Word select
    // ==============================
    always_comb begin
        next_word.raw = '0;
        if (ctrl.header_write) begin
            next_word.raw = header_sr[header_bits-1 -: word_w];
        end else if (ctrl.pixel_write) begin
            next_word.pix.pixel_lo = pixel[7:0];
            next_word.pix.pad      = 4'd0;
            next_word.pix.pixel_hi = pixel[pixel_w-1:8];
        end else if (ctrl.checksum_lo_write) begin
            next_word.raw = byte_swap(checksum_hold[15:0]);
        end else if (ctrl.checksum_hi_write) begin
            next_word.raw = byte_swap(checksum_hold[31:16]);
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        word_data <= next_word.raw;
        if (ctrl.header_load)       header_sr <= cmd_header;
        else if (ctrl.header_write) header_sr <= header_sr << word_w;
        if (ctrl.checksum_latch) checksum_hold <= checksum;
    end

    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            word_valid <= 1'b0;
            sum_en     <= 1'b0;
            word_count <= '0;
        end else begin
            word_valid <= ctrl.header_write | ctrl.pixel_write |
                          ctrl.checksum_lo_write | ctrl.checksum_hi_write;
            // Checksum words themselves stay out of the sum
            sum_en     <= ctrl.header_write | ctrl.pixel_write;
            if (ctrl.frame_clear) word_count <= '0;
            else if (word_valid)  word_count <= word_count + count_w'(1);
        end
    end

    // Sum over the little-endian view of each word
    fletcher_checksum u_checksum (
        .clk         (clk),
        .readout_rst (readout_rst),
        .clear       (ctrl.frame_clear),
        .en          (sum_en),
        .din         (byte_swap(word_data)),
        .dout        (checksum)
    );

endmodule

// File: capture/capture_fsm.sv
module capture_fsm #(
    parameter int header_words = 8,
    parameter int skip_w       = 1
) (
    input  logic              clk,
    input  logic              readout_rst,
    input  logic              cmd_capture,
    input  logic [skip_w-1:0] cmd_skip_count,
    input  logic              fv,
    input  logic              lv,
    input  logic              block_origin,
    output logic              stat_clear,
    output logic              stat_sample,
    output logic              capture_done,
    capture_ctrl_if.fsm       ctrl
);
    import capture_pkg::*;

    localparam int hdr_cnt_w = $clog2(header_words + 1);

    capture_state_e       state;
    logic                 cmd_capture_q;
    logic                 capture_start;
    logic [hdr_cnt_w-1:0] hdr_cnt;
    logic [skip_w-1:0]    skip_cnt;
    logic                 done_req;

    // Any edge on the command toggle starts a capture
    assign capture_start = cmd_capture ^ cmd_capture_q;

    // ==============================
    // State register
    // ==============================
    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            state         <= st_idle;
            cmd_capture_q <= 1'b0;
            hdr_cnt       <= '0;
            skip_cnt      <= '0;
            done_req      <= 1'b0;
            capture_done  <= 1'b0;
        end else begin
            cmd_capture_q <= cmd_capture;
            done_req      <= 1'b0;
            // Done toggles one cycle after the last checksum word
            capture_done  <= capture_done ^ done_req;

            case (state)
                st_idle: begin
                end
                st_load: begin
                    skip_cnt <= cmd_skip_count;
                    state    <= st_clear;
                end
                st_clear: begin
                    hdr_cnt <= hdr_cnt_w'(header_words - 1);
                    state   <= st_header;
                end
                st_header: begin
                    if (hdr_cnt == '0) state <= st_wait_invalid;
                    else               hdr_cnt <= hdr_cnt - hdr_cnt_w'(1);
                end
                // Sync to the start of a fresh frame
                st_wait_invalid: begin
                    if (!fv) state <= st_wait_start;
                end
                st_wait_start: begin
                    if (fv) state <= st_frame;
                end
                st_frame: begin
                    if (!fv) state <= st_checksum_lo;
                end
                st_checksum_lo: begin
                    state <= st_checksum_hi;
                end
                st_checksum_hi: begin
                    if (skip_cnt != '0) begin
                        skip_cnt <= skip_cnt - skip_w'(1);
                        state    <= st_clear;
                    end else begin
                        done_req <= 1'b1;
                        state    <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase

            if (capture_start) state <= st_load;
        end
    end

    // ==============================
    // Strobes
    // ==============================
    assign ctrl.frame_clear       = (state == st_clear);
    assign ctrl.header_load       = (state == st_clear);
    assign ctrl.header_write      = (state == st_header);
    assign ctrl.pixel_write       = (state == st_frame) && lv;
    // Last pixel has settled into the checksum by the time fv drops
    assign ctrl.checksum_latch    = (state == st_frame) && !fv;
    assign ctrl.checksum_lo_write = (state == st_checksum_lo);
    assign ctrl.checksum_hi_write = (state == st_checksum_hi);

    assign stat_clear  = (state == st_clear);
    assign stat_sample = (state == st_frame) && block_origin;

endmodule

// File: rtl/pixel_stats.sv
module pixel_stats (
    input  logic                            clk,
    input  logic                            readout_rst,
    input  logic                            clear,
    input  logic                            sample,
    input  logic [capture_pkg::pixel_w-1:0] pixel,
    output logic [capture_pkg::stat_w-1:0]  highlight_count,
    output logic [capture_pkg::stat_w-1:0]  shadow_count
);
    import capture_pkg::*;

    logic                 sample_q;
    logic [pixel_w-1:0]   pixel_q;
    logic [stat_bits-1:0] top_bits;

    // Pipeline stage ahead of the compare
    always_ff @(posedge clk) begin
        pixel_q <= pixel;
    end

    assign top_bits = pixel_q[pixel_w-1 -: stat_bits];

    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            sample_q        <= 1'b0;
            highlight_count <= '0;
            shadow_count    <= '0;
        end else begin
            sample_q <= sample;
            if (clear) begin
                highlight_count <= '0;
                shadow_count    <= '0;
            end else if (sample_q) begin
                if (top_bits == stat_highlight) highlight_count <= highlight_count + stat_w'(1);
                else if (top_bits == stat_shadow) shadow_count <= shadow_count + stat_w'(1);
            end
        end
    end

endmodule

// File: rtl/fletcher_checksum.sv
module fletcher_checksum (
    input  logic                           clk,
    input  logic                           readout_rst,
    input  logic                           clear,
    input  logic                           en,
    input  logic [15:0]                    din,
    output logic [capture_pkg::checksum_w-1:0] dout
);
    logic [15:0] sum_a;
    logic [15:0] sum_b;
    logic [16:0] a_add;
    logic [16:0] a_sub;
    logic [16:0] b_add;
    logic [16:0] b_sub;
    logic [15:0] a_next;
    logic [15:0] b_next;

    // Modulo 65535 sums where b takes the updated a
    always_comb begin
        a_add  = {1'b0, sum_a} + {1'b0, din};
        a_sub  = a_add - 17'd65535;
        a_next = (a_add >= 17'd65535) ? a_sub[15:0] : a_add[15:0];
        b_add  = {1'b0, sum_b} + {1'b0, a_next};
        b_sub  = b_add - 17'd65535;
        b_next = (b_add >= 17'd65535) ? b_sub[15:0] : b_add[15:0];
    end

    always_ff @(posedge clk) begin
        if (!readout_rst || clear) begin
            sum_a <= 16'd0;
            sum_b <= 16'd0;
        end else if (en) begin
            sum_a <= a_next;
            sum_b <= b_next;
        end
    end

    assign dout = {sum_b, sum_a};

endmodule

// File: rtl/pixel_sampler.sv
module pixel_sampler (
    input  logic                        clk,
    input  logic                        readout_rst,
    input  logic [capture_pkg::pixel_w-1:0] img_d,
    input  logic                        img_fv,
    input  logic                        img_lv,
    output logic [capture_pkg::pixel_w-1:0] pixel,
    output logic                        fv,
    output logic                        lv,
    output logic                        block_origin
);
    logic       lv_prev;
    logic [1:0] x;
    logic [1:0] y;

    // Pixel data register
    always_ff @(posedge clk) begin
        pixel <= img_d;
    end

    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            fv      <= 1'b0;
            lv      <= 1'b0;
            lv_prev <= 1'b0;
            x       <= 2'd0;
            y       <= 2'd0;
        end else begin
            fv      <= img_fv;
            lv      <= img_lv;
            lv_prev <= lv;
            // Position within the 4x4 block
            if (!lv) x <= 2'd0;
            else     x <= x + 2'd1;
            if (!fv)                 y <= 2'd0;
            else if (lv_prev && !lv) y <= y + 2'd1;
        end
    end

    // Top-left pixel of each block
    assign block_origin = lv && (x == 2'd0) && (y == 2'd0);

endmodule

// File: common/capture_ctrl_if.sv
interface capture_ctrl_if;

    // One-cycle strobes from the capture FSM
    logic frame_clear;
    logic header_load;
    logic header_write;
    logic pixel_write;
    logic checksum_latch;
    logic checksum_lo_write;
    logic checksum_hi_write;

    modport fsm (
        output frame_clear, header_load, header_write, pixel_write,
        output checksum_latch, checksum_lo_write, checksum_hi_write
    );

    modport assembler (
        input frame_clear, header_load, header_write, pixel_write,
        input checksum_latch, checksum_lo_write, checksum_hi_write
    );

endinterface

// File: common/capture_pkg.sv
package capture_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int word_w     = 16;
    localparam int pixel_w    = 12;
    localparam int stat_w     = 18;
    localparam int checksum_w = 32;

    // Top pixel bits that classify a sampled pixel
    localparam int stat_bits = 7;
    localparam logic [stat_bits-1:0] stat_highlight = '1;
    localparam logic [stat_bits-1:0] stat_shadow    = '0;

    typedef enum logic [3:0] {
        st_idle,
        st_load,
        st_clear,
        st_header,
        st_wait_invalid,
        st_wait_start,
        st_frame,
        st_checksum_lo,
        st_checksum_hi
    } capture_state_e;

    // Little-endian pixel word as it leaves the design
    typedef struct packed {
        logic [7:0] pixel_lo;
        logic [3:0] pad;
        logic [3:0] pixel_hi;
    } pixel_word_t;

    typedef union packed {
        logic [word_w-1:0] raw;
        pixel_word_t       pix;
    } out_word_u;

    function automatic logic [word_w-1:0] byte_swap(input logic [word_w-1:0] w);
        return {w[7:0], w[15:8]};
    endfunction

endpackage
